// File: logic/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and register file
`define CORE_XLEN          32
`define CORE_REG_COUNT     32
`define CORE_RETIRED_W     16

// Issue queue sizing
`define CORE_QUEUE_DEPTH   8
`define CORE_COUNT_W       $clog2(`CORE_QUEUE_DEPTH + 1)

// APB register map
`define CORE_APB_AW        12
`define CORE_ADDR_INSTR    12'h000
`define CORE_ADDR_CTRL     12'h004
`define CORE_ADDR_STATUS   12'h008
`define CORE_ADDR_REG_BASE 12'h100

`endif

// File: logic/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

    // Major opcodes handled here, all others are illegal
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } rv_opcode_e;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } alu_op_e;

endpackage

// File: logic/uop_if.sv
`timescale 1ns/100ps

interface uop_if import core_pkg::*; ();

    logic     valid;
    logic     ready;
    alu_op_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;      // already sign extended
    logic     use_imm;

    modport sender (
        output valid, op, rd, rs1, rs2, imm, use_imm,
        input  ready
    );

    modport receiver (
        input  valid, op, rd, rs1, rs2, imm, use_imm,
        output ready
    );

endinterface

// File: logic/apb_dispatch.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module apb_dispatch import core_pkg::*; (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`CORE_APB_AW-1:0]   paddr,
    input  word_t                     pwdata,
    output word_t                     prdata,
    output logic                      pready,
    output logic                      pslverr,
    uop_if.sender                     uop,
    output reg_idx_t                  rd_idx,
    input  word_t                     rd_data,
    input  logic [`CORE_COUNT_W-1:0]  count,
    input  logic                      in_flight,
    input  logic [`CORE_RETIRED_W-1:0] retired,
    output logic                      run
);

    localparam logic [`CORE_APB_AW-1:0] REG_BASE = `CORE_ADDR_REG_BASE;
    localparam logic [`CORE_APB_AW-1:0] REG_END  = REG_BASE + 4 * `CORE_REG_COUNT;

    logic       access;
    logic       instr_wr;
    logic       ctrl_wr;
    logic       reg_hit;
    logic       legal;
    logic       alt_bit;
    rv_opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      status;

    assign access   = psel & penable;
    assign instr_wr = access & pwrite & (paddr == `CORE_ADDR_INSTR);
    assign ctrl_wr  = access & pwrite & (paddr == `CORE_ADDR_CTRL);
    assign reg_hit  = (paddr >= REG_BASE) && (paddr < REG_END);

    ////////////////////////////////////////////////////////////
    // Instruction decode

    assign opcode = rv_opcode_e'(pwdata[6:0]);
    assign funct3 = pwdata[14:12];
    assign funct7 = pwdata[31:25];

    always_comb begin
        case (opcode)
            OP: begin
                legal = (funct7 == 7'h00) ||
                        ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
            end
            OP_IMM: begin
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'h00);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'h00) || (funct7 == 7'h20);
                end else begin
                    legal = 1'b1;
                end
            end
            default: legal = 1'b0;
        endcase
    end

    // funct7[5] only selects SUB/SRA, for other immediates it is imm data
    assign alt_bit = funct7[5] & ((opcode == OP) || (funct3 == 3'b101));

    assign uop.valid   = instr_wr & legal;
    assign uop.op      = alu_op_e'({alt_bit, funct3});
    assign uop.rd      = pwdata[11:7];
    assign uop.rs1     = pwdata[19:15];
    assign uop.rs2     = pwdata[24:20];
    assign uop.imm     = {{(`CORE_XLEN - 12){pwdata[31]}}, pwdata[31:20]};
    assign uop.use_imm = (opcode == OP_IMM);

    // Illegal or refused instruction words are dropped
    assign pslverr = instr_wr & (~legal | ~uop.ready);
    assign pready  = 1'b1;

    ////////////////////////////////////////////////////////////
    // Control and readback

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run <= 1'b1;
        end else if (ctrl_wr) begin
            run <= pwdata[0];
        end
    end

    assign rd_idx = paddr[$bits(reg_idx_t)+1:2];
    assign status = {retired, 7'b0, in_flight, 8'(count)};

    always_comb begin
        if (reg_hit) begin
            prdata = rd_data;
        end else begin
            case (paddr)
                `CORE_ADDR_CTRL:   prdata = word_t'(run);
                `CORE_ADDR_STATUS: prdata = status;
                default:           prdata = '0;
            endcase
        end
    end

endmodule

// File: logic/issue_queue.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module issue_queue import core_pkg::*; (
    input  logic                     clk,
    input  logic                     rstn,
    uop_if.receiver                  in,
    uop_if.sender                    out,
    output logic [`CORE_COUNT_W-1:0] count
);

    localparam int DEPTH = `CORE_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    alu_op_e    op_mem      [DEPTH];
    reg_idx_t   rd_mem      [DEPTH];
    reg_idx_t   rs1_mem     [DEPTH];
    reg_idx_t   rs2_mem     [DEPTH];
    word_t      imm_mem     [DEPTH];
    logic       use_imm_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    assign in.ready  = (count != `CORE_COUNT_W'(DEPTH));
    assign out.valid = (count != '0);

    assign push = in.valid & in.ready;
    assign pop  = out.valid & out.ready;

    // Head entry
    assign out.op      = op_mem[rd_ptr];
    assign out.rd      = rd_mem[rd_ptr];
    assign out.rs1     = rs1_mem[rd_ptr];
    assign out.rs2     = rs2_mem[rd_ptr];
    assign out.imm     = imm_mem[rd_ptr];
    assign out.use_imm = use_imm_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]      <= in.op;
            rd_mem[wr_ptr]      <= in.rd;
            rs1_mem[wr_ptr]     <= in.rs1;
            rs2_mem[wr_ptr]     <= in.rs2;
            imm_mem[wr_ptr]     <= in.imm;
            use_imm_mem[wr_ptr] <= in.use_imm;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + `CORE_COUNT_W'(push) - `CORE_COUNT_W'(pop);
        end
    end

endmodule

// File: logic/alu_retire_unit.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module alu_retire_unit import core_pkg::*; (
    input  logic                       clk,
    input  logic                       rstn,
    uop_if.receiver                    uop,
    input  logic                       run,
    input  reg_idx_t                   rd_idx,
    output word_t                      rd_data,
    output logic                       in_flight,
    output logic [`CORE_RETIRED_W-1:0] retired
);

    word_t    regs [`CORE_REG_COUNT];

    logic     take;
    logic     s1_valid;
    alu_op_e  s1_op;
    reg_idx_t s1_rd;
    reg_idx_t s1_rs1;
    reg_idx_t s1_rs2;
    word_t    s1_imm;
    logic     s1_use_imm;

    logic     s2_valid;
    reg_idx_t s2_rd;
    word_t    s2_result;

    word_t    opa;
    word_t    rs2_val;
    word_t    opb;
    word_t    alu_result;

    // Hold stops new issue only, anything already taken drains
    assign uop.ready = run;
    assign take      = uop.valid & uop.ready;
    assign in_flight = s1_valid | s2_valid;
    assign rd_data   = regs[rd_idx];

    ////////////////////////////////////////////////////////////
    // Operand read with forwarding from writeback

    always_comb begin
        opa     = regs[s1_rs1];
        rs2_val = regs[s1_rs2];
        if (s2_valid && (s2_rd != '0) && (s2_rd == s1_rs1)) begin
            opa = s2_result;
        end
        if (s2_valid && (s2_rd != '0) && (s2_rd == s1_rs2)) begin
            rs2_val = s2_result;
        end
        opb = s1_use_imm ? s1_imm : rs2_val;
    end

    always_comb begin
        case (s1_op)
            ADD:     alu_result = opa + opb;
            SUB:     alu_result = opa - opb;
            SLL:     alu_result = opa << opb[4:0];
            SLT:     alu_result = word_t'($signed(opa) < $signed(opb));
            SLTU:    alu_result = word_t'(opa < opb);
            XOR:     alu_result = opa ^ opb;
            SRL:     alu_result = opa >> opb[4:0];
            SRA:     alu_result = word_t'($signed(opa) >>> opb[4:0]);
            OR:      alu_result = opa | opb;
            AND:     alu_result = opa & opb;
            default: alu_result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Pipeline registers

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            retired  <= '0;
        end else begin
            s1_valid <= take;
            s2_valid <= s1_valid;
            if (s2_valid) begin
                retired <= retired + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1_op      <= uop.op;
            s1_rd      <= uop.rd;
            s1_rs1     <= uop.rs1;
            s1_rs2     <= uop.rs2;
            s1_imm     <= uop.imm;
            s1_use_imm <= uop.use_imm;
        end
        if (s1_valid) begin
            s2_rd     <= s1_rd;
            s2_result <= alu_result;
        end
    end

    // Register file, x0 never written
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (s2_valid && (s2_rd != '0)) begin
            regs[s2_rd] <= s2_result;
        end
    end

endmodule

// File: logic/exec_core_top.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module exec_core_top import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`CORE_APB_AW-1:0] paddr,
    input  word_t                   pwdata,
    output word_t                   prdata,
    output logic                    pready,
    output logic                    pslverr
);

    reg_idx_t                   rd_idx;
    word_t                      rd_data;
    logic [`CORE_COUNT_W-1:0]   count;
    logic                       in_flight;
    logic [`CORE_RETIRED_W-1:0] retired;
    logic                       run;

    uop_if dispatch_q ();
    uop_if queue_exe ();

    ////////////////////////////////////////////////////////////
    // APB front end and decode
    apb_dispatch i_dispatch (
        .clk       (clk),
        .rstn      (rstn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .uop       (dispatch_q.sender),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .count     (count),
        .in_flight (in_flight),
        .retired   (retired),
        .run       (run)
    );

    issue_queue i_queue (
        .clk   (clk),
        .rstn  (rstn),
        .in    (dispatch_q.receiver),
        .out   (queue_exe.sender),
        .count (count)
    );

    ////////////////////////////////////////////////////////////
    // Execute and writeback
    alu_retire_unit i_alu (
        .clk       (clk),
        .rstn      (rstn),
        .uop       (queue_exe.receiver),
        .run       (run),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .in_flight (in_flight),
        .retired   (retired)
    );

endmodule

// File: verification/exec_core_checker.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module exec_core_checker (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    output int          errors,
    output logic        timed_out
);

    localparam int CYCLE_LIMIT = 20000;

    logic [31:0] model [32];
    logic        model_run;
    logic [15:0] model_retired;
    int          held;
    logic        synced;
    int          cycles;

    // Returns {legal, result} for one instruction word
    function automatic logic [32:0] ref_exec(input logic [31:0] instr, input logic [31:0] a,
                                             input logic [31:0] rs2_val);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] b;
        logic        legal;
        logic [31:0] res;
        opc = instr[6:0];
        f3  = instr[14:12];
        f7  = instr[31:25];
        b   = (opc == 7'h13) ? {{20{instr[31]}}, instr[31:20]} : rs2_val;
        if (opc == 7'h33) begin
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end else if (opc == 7'h13) begin
            legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                    (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        end else begin
            legal = 1'b0;
        end
        case (f3)
            3'd0: res = (opc == 7'h33 && f7[5]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: res = f7[5] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return {legal, res};
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model, updated on every completed access

    always @(negedge clk) begin
        logic [32:0] r;
        logic        exp_err;
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                model[i] = '0;
            end
            model_run     = 1'b1;
            model_retired = '0;
            held          = 0;
            synced        = 1'b1;
        end else if (psel && penable) begin
            if (pready !== 1'b1) begin
                $display("APB access phase completed without pready high");
                errors++;
            end
            if (pwrite && paddr == `CORE_ADDR_INSTR) begin
                r = ref_exec(pwdata, model[pwdata[19:15]], model[pwdata[24:20]]);
                exp_err = !r[32] || (!model_run && held == `CORE_QUEUE_DEPTH);
                compare("pslverr", {31'b0, exp_err}, {31'b0, pslverr});
                if (!exp_err) begin
                    if (pwdata[11:7] != 5'd0) begin
                        model[pwdata[11:7]] = r[31:0];
                    end
                    model_retired = model_retired + 16'd1;
                    synced = 1'b0;
                    if (!model_run) begin
                        held++;
                    end
                end
            end else begin
                compare("pslverr", 32'h0, {31'b0, pslverr});
                if (pwrite && paddr == `CORE_ADDR_CTRL) begin
                    model_run = pwdata[0];
                    if (pwdata[0]) begin
                        held = 0;
                    end
                end else if (!pwrite && paddr == `CORE_ADDR_CTRL) begin
                    compare("prdata(ctrl)", {31'b0, model_run}, prdata);
                end else if (!pwrite && paddr == `CORE_ADDR_STATUS) begin
                    // Held instructions count as accepted but not retired
                    if (!model_run || synced || prdata[8:0] == 9'd0) begin
                        compare("prdata(status)",
                                {model_retired - 16'(held), 8'b0, 8'(held)}, prdata);
                        synced = model_run;
                    end
                end else if (!pwrite && paddr >= 12'h100 && paddr < 12'h180 && synced) begin
                    compare($sformatf("prdata(x%0d)", paddr[6:2]), model[paddr[6:2]], prdata);
                end
            end
        end
    end

    initial begin
        errors    = 0;
        timed_out = 1'b0;
        cycles    = 0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            timed_out = 1'b1;
        end
    end

endmodule

// File: verification/exec_core_tb.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module exec_core_tb;

    logic        clk;
    logic        rstn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    int          errors;
    logic        timed_out;
    logic [31:0] lfsr;
    int          tests_passed;
    int          tests_failed;
    int          errs_at_start;

    exec_core_top i_dut (.*);

    exec_core_checker i_chk (.*);

    always #50 clk = ~clk;

    always @(posedge timed_out) begin
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    ////////////////////////////////////////////////////////////
    // APB driver

    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic poll_idle();
        logic [31:0] st;
        st = 32'hffff_ffff;
        while (st[8:0] != 9'd0) begin
            apb_read(`CORE_ADDR_STATUS, st);
        end
    endtask

    task automatic read_all_regs();
        logic [31:0] d;
        for (int r = 0; r < 32; r++) begin
            apb_read(12'(`CORE_ADDR_REG_BASE + 4 * r), d);
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - errs_at_start;
        if (n == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %-14s %s (%0d errors)", name, (n == 0) ? "passed" : "failed", n);
        errs_at_start = errors;
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] form;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] f3;
        logic [31:0] sel;
        logic [31:0] imm;
        logic [31:0] instr;
        clk = 1'b0;
        rstn = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lfsr = 32'h57f4b7c1;
        tests_passed = 0;
        tests_failed = 0;
        errs_at_start = 0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        read_all_regs();
        apb_read(`CORE_ADDR_STATUS, d);
        apb_read(`CORE_ADDR_CTRL, d);
        end_test("reset");

        // Operand setup, then every R and I form
        apb_write(`CORE_ADDR_INSTR, i_type(12'hffb, 5'd0, 3'd0, 5'd1));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h007, 5'd0, 3'd0, 5'd2));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h7ff, 5'd0, 3'd0, 5'd3));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h014, 5'd3, 3'd1, 5'd4));
        for (int f = 0; f < 8; f++) begin
            apb_write(`CORE_ADDR_INSTR, r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'(5 + f)));
        end
        apb_write(`CORE_ADDR_INSTR, r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd13));
        apb_write(`CORE_ADDR_INSTR, r_type(7'h20, 5'd2, 5'd4, 3'd5, 5'd14));
        apb_write(`CORE_ADDR_INSTR, r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd15));
        apb_write(`CORE_ADDR_INSTR, i_type(12'hfff, 5'd1, 3'd2, 5'd16));
        apb_write(`CORE_ADDR_INSTR, i_type(12'hfff, 5'd2, 3'd3, 5'd17));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h555, 5'd1, 3'd4, 5'd18));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h004, 5'd1, 3'd5, 5'd19));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h404, 5'd1, 3'd5, 5'd20));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h100, 5'd2, 3'd6, 5'd21));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h0f0, 5'd1, 3'd7, 5'd22));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h123, 5'd1, 3'd0, 5'd23));
        // Dependent chain issued back to back from a held queue
        apb_write(`CORE_ADDR_CTRL, 32'h0);
        apb_write(`CORE_ADDR_INSTR, i_type(12'h001, 5'd0, 3'd0, 5'd24));
        repeat (3) apb_write(`CORE_ADDR_INSTR, r_type(7'h00, 5'd24, 5'd24, 3'd0, 5'd24));
        apb_write(`CORE_ADDR_INSTR, r_type(7'h20, 5'd1, 5'd24, 3'd0, 5'd25));
        apb_write(`CORE_ADDR_INSTR, r_type(7'h00, 5'd24, 5'd25, 3'd4, 5'd26));
        apb_write(`CORE_ADDR_CTRL, 32'h1);
        poll_idle();
        read_all_regs();
        end_test("directed");

        apb_write(`CORE_ADDR_INSTR, i_type(12'h005, 5'd0, 3'd0, 5'd0));
        apb_write(`CORE_ADDR_INSTR, r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        poll_idle();
        apb_read(`CORE_ADDR_REG_BASE, d);
        end_test("rd_zero");

        apb_write(`CORE_ADDR_INSTR, 32'h0000_2083);
        apb_write(`CORE_ADDR_INSTR, 32'h0020_8063);
        apb_write(`CORE_ADDR_INSTR, r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd5));
        apb_write(`CORE_ADDR_INSTR, r_type(7'h20, 5'd2, 5'd1, 3'd1, 5'd5));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h401, 5'd1, 3'd1, 5'd5));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h201, 5'd1, 3'd5, 5'd5));
        poll_idle();
        read_all_regs();
        end_test("illegal");

        apb_write(`CORE_ADDR_CTRL, 32'h0);
        apb_write(`CORE_ADDR_INSTR, i_type(12'h001, 5'd0, 3'd0, 5'd27));
        repeat (3) apb_write(`CORE_ADDR_INSTR, i_type(12'h001, 5'd27, 3'd1, 5'd27));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h005, 5'd27, 3'd0, 5'd27));
        apb_write(`CORE_ADDR_INSTR, r_type(7'h20, 5'd2, 5'd27, 3'd0, 5'd28));
        apb_write(`CORE_ADDR_INSTR, i_type(12'h401, 5'd28, 3'd5, 5'd29));
        apb_write(`CORE_ADDR_INSTR, r_type(7'h00, 5'd27, 5'd29, 3'd6, 5'd30));
        apb_read(`CORE_ADDR_STATUS, d);
        apb_write(`CORE_ADDR_INSTR, i_type(12'h063, 5'd0, 3'd0, 5'd31));
        apb_write(`CORE_ADDR_CTRL, 32'h1);
        poll_idle();
        read_all_regs();
        end_test("backpressure");

        for (int n = 0; n < 400; n++) begin
            rand_bits(1, form);
            rand_bits(5, rd);
            rand_bits(5, rs1);
            rand_bits(5, rs2);
            rand_bits(3, f3);
            rand_bits(4, sel);
            rand_bits(12, imm);
            if (form[0]) begin
                instr = r_type(sel[0] ? 7'h20 : 7'h00, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]);
            end else begin
                if (f3[1:0] == 2'b01) begin
                    imm[11:5] = (sel[0] && f3[2]) ? 7'h20 : 7'h00;
                end
                instr = i_type(imm[11:0], rs1[4:0], f3[2:0], rd[4:0]);
            end
            if (sel[3:0] == 4'hf) begin
                rand_bits(7, imm);
                instr[31:25] = imm[6:0];
            end else if (sel[3:0] == 4'he) begin
                rand_bits(7, imm);
                instr[6:0] = imm[6:0];
            end
            apb_write(`CORE_ADDR_INSTR, instr);
        end
        poll_idle();
        read_all_regs();
        end_test("random");

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/core_pkg.sv
logic/uop_if.sv
logic/apb_dispatch.sv
logic/issue_queue.sv
logic/alu_retire_unit.sv
logic/exec_core_top.sv
verification/exec_core_checker.sv
verification/exec_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module exec_core_tb \
    --Mdir obj_dir -o exec_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/exec_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi

exit 0
